// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := bmd_ep_tb
FILELIST   := bmd_ep.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing
PASS_MSG   := All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== bmd_ep.f ====
hdl/bmd_pkg.sv
hdl/bmd_wb_regs.sv
hdl/bmd_tx_engine.sv
hdl/bmd_timestamp_ram.sv
hdl/bmd_rx_engine.sv
hdl/bmd_latency_stats.sv
hdl/bmd_ep.sv
sim/bmd_ep_tb.sv

// ==== hdl/bmd_ep.sv ====
//////////////////////////////////////////////////////////////////////
// Latency endpoint top. Wishbone control, request and completion
// streams, wired to the engines, memory and statistics.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module bmd_ep #(
  parameter int TS_DEPTH = 2 ** bmd_pkg::TAG_W
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  logic [bmd_pkg::WB_AW-1:0]   wb_adr_i,
  input  logic [bmd_pkg::WB_DW-1:0]   wb_dat_i,
  output logic [bmd_pkg::WB_DW-1:0]   wb_dat_o,
  output logic                        wb_ack_o,
  output bmd_pkg::bmd_req_t           req_o,
  output logic                        req_valid_o,
  input  logic                        req_ready_i,
  input  bmd_pkg::bmd_cpl_t           cpl_i,
  input  logic                        cpl_valid_i,
  output logic                        cpl_ready_o
);

  logic                      init, run, cpl_done;
  logic [bmd_pkg::LEN_W-1:0] pkt_len;
  logic [bmd_pkg::CNT_W-1:0] pkt_num, tx_count, cpl_count;
  logic                      ts_we;
  logic [bmd_pkg::TAG_W-1:0] ts_wtag, ts_rtag;
  logic [bmd_pkg::TS_W-1:0]  ts_wdata, ts_rdata, now;
  logic [bmd_pkg::TS_W-1:0]  lat_min, lat_max, lat_sum;
  bmd_pkg::bmd_lat_t         sample;

  bmd_wb_regs u_regs (
    .clk, .rst_n, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
    .wb_dat_o, .wb_ack_o,
    .tx_count_i(tx_count), .cpl_count_i(cpl_count),
    .lat_min_i(lat_min), .lat_max_i(lat_max), .lat_sum_i(lat_sum),
    .init_o(init), .run_o(run), .pkt_len_o(pkt_len), .pkt_num_o(pkt_num)
  );

  bmd_tx_engine #(.TS_DEPTH(TS_DEPTH)) u_tx (
    .clk, .rst_n, .init_i(init), .run_i(run), .pkt_len_i(pkt_len),
    .pkt_num_i(pkt_num), .cpl_done_i(cpl_done),
    .req_o, .req_valid_o, .req_ready_i,
    .ts_we_o(ts_we), .ts_wtag_o(ts_wtag), .ts_wdata_o(ts_wdata),
    .now_o(now), .tx_count_o(tx_count)
  );

  bmd_timestamp_ram #(.TS_DEPTH(TS_DEPTH)) u_ts_ram (
    .clk, .we_i(ts_we), .wtag_i(ts_wtag), .wdata_i(ts_wdata),
    .rtag_i(ts_rtag), .rdata_o(ts_rdata)
  );

  bmd_rx_engine u_rx (
    .clk, .rst_n, .init_i(init), .cpl_i, .cpl_valid_i, .cpl_ready_o,
    .now_i(now), .ts_rtag_o(ts_rtag), .ts_rdata_i(ts_rdata),
    .sample_o(sample), .cpl_done_o(cpl_done)
  );

  bmd_latency_stats u_stats (
    .clk, .rst_n, .init_i(init), .sample_i(sample),
    .lat_min_o(lat_min), .lat_max_o(lat_max), .lat_sum_o(lat_sum),
    .cpl_count_o(cpl_count)
  );

endmodule

`default_nettype wire

// ==== hdl/bmd_latency_stats.sv ====
//////////////////////////////////////////////////////////////////////
// Latency statistics. Running min, max, wrapping sum and sample
// count, cleared at the start of every run.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module bmd_latency_stats (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        init_i,
  input  bmd_pkg::bmd_lat_t           sample_i,
  output logic [bmd_pkg::TS_W-1:0]    lat_min_o,
  output logic [bmd_pkg::TS_W-1:0]    lat_max_o,
  output logic [bmd_pkg::TS_W-1:0]    lat_sum_o,
  output logic [bmd_pkg::CNT_W-1:0]   cpl_count_o
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lat_min_o   <= '1;                  // Any sample beats it
      lat_max_o   <= '0;
      lat_sum_o   <= '0;
      cpl_count_o <= '0;
    end else if (init_i) begin
      lat_min_o   <= '1;
      lat_max_o   <= '0;
      lat_sum_o   <= '0;
      cpl_count_o <= '0;
    end else if (sample_i.vld) begin
      if (sample_i.lat < lat_min_o) lat_min_o <= sample_i.lat;
      if (sample_i.lat > lat_max_o) lat_max_o <= sample_i.lat;
      lat_sum_o   <= lat_sum_o + sample_i.lat;   // Wraps at 32 bits
      cpl_count_o <= cpl_count_o + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/bmd_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared widths, register map and stream payload types for the
// latency endpoint. Referenced by scoped name from every module.
//////////////////////////////////////////////////////////////////////
`default_nettype none

package bmd_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////
  localparam int TAG_W = 4;    // 16 outstanding tags
  localparam int TS_W  = 32;   // Timestamp and latency
  localparam int LEN_W = 10;   // Packet length in DW
  localparam int CNT_W = 16;   // Packet and completion counts
  localparam int WB_AW = 3;    // Word address
  localparam int WB_DW = 32;   // Bus data

  //////////////////////////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////////////////////////
  localparam logic [WB_AW-1:0] REG_CTRL      = 3'd0; // W bit0 start, R bit1 busy, bit2 done
  localparam logic [WB_AW-1:0] REG_PKT_LEN   = 3'd1;
  localparam logic [WB_AW-1:0] REG_PKT_NUM   = 3'd2;
  localparam logic [WB_AW-1:0] REG_TX_COUNT  = 3'd3; // Read only from here on
  localparam logic [WB_AW-1:0] REG_CPL_COUNT = 3'd4;
  localparam logic [WB_AW-1:0] REG_LAT_MIN   = 3'd5;
  localparam logic [WB_AW-1:0] REG_LAT_MAX   = 3'd6;
  localparam logic [WB_AW-1:0] REG_LAT_SUM   = 3'd7;

  //////////////////////////////////////////////////////////////////////
  // Stream payloads
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [TAG_W-1:0] tag;     // Slot in timestamp memory
    logic [LEN_W-1:0] len;     // Requested DW
  } bmd_req_t;

  typedef struct packed {
    logic [TAG_W-1:0] tag;     // Echo of request tag
    logic [LEN_W-1:0] len;     // Returned DW
  } bmd_cpl_t;

  typedef struct packed {
    logic            vld;      // One sample this cycle
    logic [TS_W-1:0] lat;      // Round trip in clocks
  } bmd_lat_t;

endpackage

`default_nettype wire

// ==== hdl/bmd_rx_engine.sv ====
//////////////////////////////////////////////////////////////////////
// Completion receive engine. Stage 1 captures tag and arrival time,
// stage 2 subtracts the stored send time and frees the slot.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module bmd_rx_engine (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        init_i,
  input  bmd_pkg::bmd_cpl_t           cpl_i,
  input  logic                        cpl_valid_i,
  output logic                        cpl_ready_o,
  input  logic [bmd_pkg::TS_W-1:0]    now_i,
  output logic [bmd_pkg::TAG_W-1:0]   ts_rtag_o,
  input  logic [bmd_pkg::TS_W-1:0]    ts_rdata_i,
  output bmd_pkg::bmd_lat_t           sample_o,
  output logic                        cpl_done_o
);

  logic                      fire;        // Completion transfer
  logic                      s1_vld;
  logic [bmd_pkg::TAG_W-1:0] s1_tag;
  logic [bmd_pkg::TS_W-1:0]  s1_arr;      // Arrival time
  logic                      s2_vld;
  logic [bmd_pkg::TS_W-1:0]  s2_arr;

  assign cpl_ready_o = ~init_i;           // Only init holds off the link
  assign fire        = cpl_valid_i & cpl_ready_o;
  assign ts_rtag_o   = s1_tag;            // Memory read during stage 1

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld <= 1'b0;
      s2_vld <= 1'b0;
    end else if (init_i) begin
      s1_vld <= 1'b0;
      s2_vld <= 1'b0;
    end else begin
      s1_vld <= fire;
      s2_vld <= s1_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      s1_tag <= cpl_i.tag;
      s1_arr <= now_i;                    // Time at the transfer edge
    end
    s2_arr <= s1_arr;                     // Lines up with read data
  end

  // Stage 2 output
  assign sample_o.vld = s2_vld;
  assign sample_o.lat = s2_arr - ts_rdata_i;
  assign cpl_done_o   = s2_vld;           // Slot back to tx engine

endmodule

`default_nettype wire

// ==== hdl/bmd_timestamp_ram.sv ====
//////////////////////////////////////////////////////////////////////
// Send-time memory, one word per tag. Write port from the tx engine,
// registered read port for the rx engine.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module bmd_timestamp_ram #(
  parameter int TS_DEPTH = 16
) (
  input  logic                        clk,
  input  logic                        we_i,
  input  logic [bmd_pkg::TAG_W-1:0]   wtag_i,
  input  logic [bmd_pkg::TS_W-1:0]    wdata_i,
  input  logic [bmd_pkg::TAG_W-1:0]   rtag_i,
  output logic [bmd_pkg::TS_W-1:0]    rdata_o
);

  logic [bmd_pkg::TS_W-1:0] mem [TS_DEPTH];     // Block RAM

  always_ff @(posedge clk) begin
    if (we_i) mem[wtag_i] <= wdata_i;
  end

  always_ff @(posedge clk) begin
    rdata_o <= mem[rtag_i];                     // One cycle read
  end

endmodule

`default_nettype wire

// ==== hdl/bmd_tx_engine.sv ====
//////////////////////////////////////////////////////////////////////
// Request issue engine. Sends tagged requests while slots are free
// and stamps each transfer with the free-running time counter.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module bmd_tx_engine #(
  parameter int TS_DEPTH = 16
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        init_i,
  input  logic                        run_i,
  input  logic [bmd_pkg::LEN_W-1:0]   pkt_len_i,
  input  logic [bmd_pkg::CNT_W-1:0]   pkt_num_i,
  input  logic                        cpl_done_i,
  output bmd_pkg::bmd_req_t           req_o,
  output logic                        req_valid_o,
  input  logic                        req_ready_i,
  output logic                        ts_we_o,
  output logic [bmd_pkg::TAG_W-1:0]   ts_wtag_o,
  output logic [bmd_pkg::TS_W-1:0]    ts_wdata_o,
  output logic [bmd_pkg::TS_W-1:0]    now_o,
  output logic [bmd_pkg::CNT_W-1:0]   tx_count_o
);

  localparam int OUT_W = $clog2(TS_DEPTH + 1);

  logic [bmd_pkg::TAG_W-1:0] tag;           // Sent count mod TS_DEPTH
  logic [OUT_W-1:0]          outstanding;
  logic                      fire;          // Request transfer

  assign req_valid_o = run_i & (tx_count_o < pkt_num_i)
                     & (outstanding < OUT_W'(TS_DEPTH));
  assign req_o.tag   = tag;
  assign req_o.len   = pkt_len_i;
  assign fire        = req_valid_o & req_ready_i;

  // Stamp goes straight to memory on the transfer edge
  assign ts_we_o    = fire;
  assign ts_wtag_o  = tag;
  assign ts_wdata_o = now_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) now_o <= '0;
    else        now_o <= now_o + 1'b1;      // Never stalls
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tag         <= '0;
      outstanding <= '0;
      tx_count_o  <= '0;
    end else if (init_i) begin
      tag         <= '0;
      outstanding <= '0;
      tx_count_o  <= '0;
    end else begin
      if (fire) begin
        tx_count_o <= tx_count_o + 1'b1;
        if (tag == bmd_pkg::TAG_W'(TS_DEPTH - 1)) tag <= '0;   // Wrap at depth
        else                                      tag <= tag + 1'b1;
      end
      case ({fire, cpl_done_i})
        2'b10:   outstanding <= outstanding + 1'b1;
        2'b01:   outstanding <= outstanding - 1'b1;
        default: outstanding <= outstanding;        // Both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/bmd_wb_regs.sv ====
//////////////////////////////////////////////////////////////////////
// Wishbone classic register slave. Holds the run settings, turns a
// start write into init then run, and flags done at the last completion.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module bmd_wb_regs (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  logic [bmd_pkg::WB_AW-1:0]   wb_adr_i,
  input  logic [bmd_pkg::WB_DW-1:0]   wb_dat_i,
  output logic [bmd_pkg::WB_DW-1:0]   wb_dat_o,
  output logic                        wb_ack_o,
  input  logic [bmd_pkg::CNT_W-1:0]   tx_count_i,
  input  logic [bmd_pkg::CNT_W-1:0]   cpl_count_i,
  input  logic [bmd_pkg::TS_W-1:0]    lat_min_i,
  input  logic [bmd_pkg::TS_W-1:0]    lat_max_i,
  input  logic [bmd_pkg::TS_W-1:0]    lat_sum_i,
  output logic                        init_o,
  output logic                        run_o,
  output logic [bmd_pkg::LEN_W-1:0]   pkt_len_o,
  output logic [bmd_pkg::CNT_W-1:0]   pkt_num_o
);

  logic                      acc;       // First cycle of an access
  logic                      start_wr;  // Start bit written to CTRL
  logic                      busy;
  logic                      done;
  logic                      last_cpl;  // All completions counted
  logic [bmd_pkg::WB_DW-1:0] rd_word;

  assign acc      = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign start_wr = acc & wb_we_i & (wb_adr_i == bmd_pkg::REG_CTRL) & wb_dat_i[0];
  assign busy     = run_o | init_o;                 // Init counts as busy
  assign last_cpl = run_o & (cpl_count_i == pkt_num_o);

  //////////////////////////////////////////////////////////////////////
  // Bus access and settings
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack_o  <= 1'b0;
      pkt_len_o <= '0;
      pkt_num_o <= '0;
    end else begin
      wb_ack_o <= acc;                              // Single cycle ack
      if (acc && wb_we_i && wb_adr_i == bmd_pkg::REG_PKT_LEN)
        pkt_len_o <= wb_dat_i[bmd_pkg::LEN_W-1:0];
      if (acc && wb_we_i && wb_adr_i == bmd_pkg::REG_PKT_NUM)
        pkt_num_o <= wb_dat_i[bmd_pkg::CNT_W-1:0];
    end
  end

  always_comb begin
    rd_word = '0;
    case (wb_adr_i)
      bmd_pkg::REG_CTRL:      rd_word[2:1] = {done, busy};
      bmd_pkg::REG_PKT_LEN:   rd_word[bmd_pkg::LEN_W-1:0] = pkt_len_o;
      bmd_pkg::REG_PKT_NUM:   rd_word[bmd_pkg::CNT_W-1:0] = pkt_num_o;
      bmd_pkg::REG_TX_COUNT:  rd_word[bmd_pkg::CNT_W-1:0] = tx_count_i;
      bmd_pkg::REG_CPL_COUNT: rd_word[bmd_pkg::CNT_W-1:0] = cpl_count_i;
      bmd_pkg::REG_LAT_MIN:   rd_word = lat_min_i;
      bmd_pkg::REG_LAT_MAX:   rd_word = lat_max_i;
      default:                rd_word = lat_sum_i;  // REG_LAT_SUM
    endcase
  end

  always_ff @(posedge clk) begin
    if (acc) wb_dat_o <= rd_word;                   // Held while ack high
  end

  //////////////////////////////////////////////////////////////////////
  // Run sequencing
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      init_o <= 1'b0;
      run_o  <= 1'b0;
      done   <= 1'b0;
    end else begin
      init_o <= start_wr & ~busy;                   // Start while busy dropped
      if (init_o) begin
        run_o <= 1'b1;                              // Run follows init
        done  <= 1'b0;
      end else if (last_cpl) begin
        run_o <= 1'b0;
        done  <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== sim/bmd_ep_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the latency endpoint. Random link model with
// out-of-order completions, reference latency model, Wishbone checks.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module bmd_ep_tb;

  localparam int TAGS = 2 ** bmd_pkg::TAG_W;      // Outstanding limit

  logic                         clk         = 1'b0;
  logic                         rst_n       = 1'b0;
  logic                         wb_cyc_i    = 1'b0;
  logic                         wb_stb_i    = 1'b0;
  logic                         wb_we_i     = 1'b0;
  logic [bmd_pkg::WB_AW-1:0]    wb_adr_i    = '0;
  logic [bmd_pkg::WB_DW-1:0]    wb_dat_i    = '0;
  logic [bmd_pkg::WB_DW-1:0]    wb_dat_o;
  logic                         wb_ack_o;
  bmd_pkg::bmd_req_t            req_o;
  logic                         req_valid_o;
  logic                         req_ready_i = 1'b0;
  bmd_pkg::bmd_cpl_t            cpl_i       = '0;
  logic                         cpl_valid_i = 1'b0;
  logic                         cpl_ready_o;

  // Link and reference model state
  int                           edge_cnt    = 0;   // Rising edges so far
  int                           cycle_limit = 0;
  int                           tx_idx      = 0;   // Requests seen this run
  int                           send_time [TAGS];  // Edge of last send per tag
  logic [bmd_pkg::TAG_W-1:0]    pend_q [$];        // Tags not yet completed
  logic [bmd_pkg::LEN_W-1:0]    cur_len     = '0;
  bit                           link_hold   = 1'b0;
  bit                           stalled     = 1'b0;
  bmd_pkg::bmd_req_t            held_req    = '0;
  logic [bmd_pkg::TS_W-1:0]     m_min       = '1;
  logic [bmd_pkg::TS_W-1:0]     m_max       = '0;
  logic [bmd_pkg::TS_W-1:0]     m_sum       = '0;
  int                           m_cnt       = 0;

  bmd_ep #(.TS_DEPTH(TAGS)) bmd_ep_i (
    .clk, .rst_n, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
    .wb_dat_o, .wb_ack_o, .req_o, .req_valid_o, .req_ready_i,
    .cpl_i, .cpl_valid_i, .cpl_ready_o
  );

  always #10 clk = ~clk;                           // 20 ns period

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and compares
  //////////////////////////////////////////////////////////////////////
  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_req(input string name, input bmd_pkg::bmd_req_t exp,
                           input bmd_pkg::bmd_req_t act);
    if (act !== exp)
      abort_run($sformatf("[FAIL] %s: expected tag %0d len %0d, actual tag %0d len %0d",
                          name, exp.tag, exp.len, act.tag, act.len));
  endtask

  task automatic verify_word(input string name, input logic [bmd_pkg::WB_DW-1:0] exp,
                             input logic [bmd_pkg::WB_DW-1:0] act);
    if (act !== exp)
      abort_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
  endtask

  always @(posedge clk) begin
    edge_cnt <= edge_cnt + 1;
    if (edge_cnt > cycle_limit)
      abort_run($sformatf("simulation timed out after %0d cycles", edge_cnt));
  end

  //////////////////////////////////////////////////////////////////////
  // Wishbone classic master
  //////////////////////////////////////////////////////////////////////
  task automatic wb_access(input bit we, input logic [bmd_pkg::WB_AW-1:0] adr,
                           input logic [bmd_pkg::WB_DW-1:0] dat,
                           output logic [bmd_pkg::WB_DW-1:0] rd);
    @(negedge clk);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    @(negedge clk);
    if (wb_ack_o !== 1'b1) abort_run("Wishbone ack missing in the cycle after the access");
    rd       = wb_dat_o;                           // Valid while ack high
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    @(negedge clk);
    if (wb_ack_o !== 1'b0) abort_run("Wishbone ack held for more than one cycle");
  endtask

  task automatic write_reg(input logic [bmd_pkg::WB_AW-1:0] adr,
                           input logic [bmd_pkg::WB_DW-1:0] dat);
    logic [bmd_pkg::WB_DW-1:0] rd;
    wb_access(1'b1, adr, dat, rd);
  endtask

  task automatic expect_reg(input string name, input logic [bmd_pkg::WB_AW-1:0] adr,
                            input logic [bmd_pkg::WB_DW-1:0] exp);
    logic [bmd_pkg::WB_DW-1:0] rd;
    wb_access(1'b0, adr, '0, rd);
    verify_word(name, exp, rd);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Link model, one decision per cycle on the falling edge
  //////////////////////////////////////////////////////////////////////
  always @(negedge clk) begin : link_model
    int                        idx;
    bit                        cpl_go;
    logic [bmd_pkg::TAG_W-1:0] ctag;
    logic [bmd_pkg::TS_W-1:0]  lat;
    bmd_pkg::bmd_req_t         exp_req;
    ctag = '0;
    if (stalled && (req_valid_o !== 1'b1 || req_o !== held_req))
      abort_run("request changed while stalled");
    if (!link_hold && cpl_ready_o !== 1'b1)       // Only a run start may hold it off
      abort_run("completion ready low outside a run start");
    req_ready_i = !link_hold && ($urandom % 4 != 0);   // Random back-pressure
    stalled     = req_valid_o && !req_ready_i;
    held_req    = req_o;
    cpl_go      = cpl_ready_o && pend_q.size() > 0 && ($urandom % 2 == 0);
    if (cpl_go) begin
      idx  = $urandom % pend_q.size();             // Any outstanding tag
      ctag = pend_q[idx];
      pend_q.delete(idx);
    end
    if (req_valid_o && req_ready_i) begin
      exp_req.tag = bmd_pkg::TAG_W'(tx_idx % TAGS);
      exp_req.len = cur_len;
      check_req($sformatf("request %0d", tx_idx), exp_req, req_o);
      send_time[req_o.tag] = edge_cnt + 1;         // Edge of this transfer
      pend_q.push_back(req_o.tag);
      tx_idx++;
      if (pend_q.size() > TAGS) abort_run("more requests outstanding than tags");
    end
    cpl_valid_i = cpl_go;
    cpl_i       = '0;
    if (cpl_go) begin
      cpl_i.tag = ctag;
      cpl_i.len = bmd_pkg::LEN_W'($urandom);
      lat       = edge_cnt + 1 - send_time[ctag];  // Send edge to completion edge
      if (lat < m_min) m_min = lat;
      if (lat > m_max) m_max = lat;
      m_sum = m_sum + lat;
      m_cnt++;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Runs
  //////////////////////////////////////////////////////////////////////
  task automatic run_and_check(input string name, input logic [bmd_pkg::LEN_W-1:0] len,
                               input logic [bmd_pkg::CNT_W-1:0] num);
    logic [bmd_pkg::WB_DW-1:0] ctrl;
    write_reg(bmd_pkg::REG_PKT_LEN, 32'(len));
    write_reg(bmd_pkg::REG_PKT_NUM, 32'(num));
    tx_idx    = 0;
    cur_len   = len;
    m_min     = '1;
    m_max     = '0;
    m_sum     = '0;
    m_cnt     = 0;
    link_hold = 1'b1;                              // No transfers until cleared state read
    write_reg(bmd_pkg::REG_CTRL, 32'h1);
    expect_reg({name, " cleared TX_COUNT"}, bmd_pkg::REG_TX_COUNT, 32'h0);
    expect_reg({name, " cleared CPL_COUNT"}, bmd_pkg::REG_CPL_COUNT, 32'h0);
    expect_reg({name, " cleared LAT_MIN"}, bmd_pkg::REG_LAT_MIN, 32'hffff_ffff);
    expect_reg({name, " cleared LAT_MAX"}, bmd_pkg::REG_LAT_MAX, 32'h0);
    expect_reg({name, " cleared LAT_SUM"}, bmd_pkg::REG_LAT_SUM, 32'h0);
    link_hold = 1'b0;
    repeat (6) @(negedge clk);
    expect_reg({name, " busy"}, bmd_pkg::REG_CTRL, 32'h2);
    write_reg(bmd_pkg::REG_CTRL, 32'h1);           // Start while busy
    ctrl = '0;
    while (!ctrl[2]) wb_access(1'b0, bmd_pkg::REG_CTRL, '0, ctrl);
    verify_word({name, " done"}, 32'h4, ctrl);
    verify_word({name, " model count"}, 32'(num), 32'(m_cnt));
    expect_reg({name, " TX_COUNT"}, bmd_pkg::REG_TX_COUNT, 32'(num));
    expect_reg({name, " CPL_COUNT"}, bmd_pkg::REG_CPL_COUNT, 32'(num));
    expect_reg({name, " LAT_MIN"}, bmd_pkg::REG_LAT_MIN, m_min);
    expect_reg({name, " LAT_MAX"}, bmd_pkg::REG_LAT_MAX, m_max);
    expect_reg({name, " LAT_SUM"}, bmd_pkg::REG_LAT_SUM, m_sum);
  endtask

  initial begin : main
    int                        num_a;
    int                        num_b;
    logic [bmd_pkg::LEN_W-1:0] len;
    logic [bmd_pkg::CNT_W-1:0] num;
    void'($urandom(3659));
    num_a       = 20 + int'($urandom % 41);
    num_b       = 20 + int'($urandom % 41);
    cycle_limit = (num_a + num_b) * 40 + 2000;     // Packets times 40 plus setup
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (req_valid_o !== 1'b0 || wb_ack_o !== 1'b0)
      abort_run("request valid or Wishbone ack high after reset");
    for (int a = 0; a < 8; a++)
      expect_reg($sformatf("reset value of register %0d", a), bmd_pkg::WB_AW'(a),
                 (bmd_pkg::WB_AW'(a) == bmd_pkg::REG_LAT_MIN) ? 32'hffff_ffff : 32'h0);
    repeat (4) begin
      len = bmd_pkg::LEN_W'($urandom);
      num = bmd_pkg::CNT_W'($urandom);
      write_reg(bmd_pkg::REG_PKT_LEN, 32'(len));
      write_reg(bmd_pkg::REG_PKT_NUM, 32'(num));
      expect_reg("PKT_LEN readback", bmd_pkg::REG_PKT_LEN, 32'(len));
      expect_reg("PKT_NUM readback", bmd_pkg::REG_PKT_NUM, 32'(num));
    end
    run_and_check("run 1", bmd_pkg::LEN_W'($urandom), bmd_pkg::CNT_W'(num_a));
    run_and_check("run 2", bmd_pkg::LEN_W'($urandom), bmd_pkg::CNT_W'(num_b));
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire
